// ==== hw/audio_pkg.sv ====
package audio_pkg;

    localparam int SAMPLE_BITS = 16;
    localparam int BIT_CNT_BITS = $clog2(SAMPLE_BITS) + 1;

    // Frame shape of the serial stream, in i_clk cycles.
    localparam int FRAME_CYCLES = 40;
    localparam int HALF_FRAME_CYCLES = FRAME_CYCLES / 2;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [BIT_CNT_BITS-1:0] bit_cnt_t;

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(SAMPLE_BITS - 1); // Index of the LSB slot.

    typedef enum logic [2:0] {
        R_IDLE,
        R_WAIT,
        R_REC,
        R_WRITE,
        R_PAUSE,
        R_FINISH
    } rec_state_t;

    typedef enum logic [2:0] {
        P_IDLE,
        P_FETCH,
        P_WAIT_LOW,
        P_SHIFT,
        P_DONE
    } play_state_t;

endpackage

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // Number of sample slots; any power of two works.
    localparam int MEM_DEPTH = 1024;
    localparam int IDX_BITS = $clog2(MEM_DEPTH);

    // Wide enough for an external SRAM address bus.
    localparam int ADDR_BITS = 20;

    typedef logic [ADDR_BITS-1:0] addr_t;

    localparam addr_t LAST_ADDR = addr_t'(MEM_DEPTH - 1);

endpackage

// ==== hw/sample_if.sv ====
`timescale 1ns/1ps

// Four-phase req/ack access to the sample store.
interface sample_if;

    logic               req;
    logic               ack;
    logic               we;
    mem_pkg::addr_t     addr;
    audio_pkg::sample_t wdata;
    audio_pkg::sample_t rdata;  // Valid while ack is high on a read.

    modport client (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport store (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

// ==== hw/aud_recorder.sv ====
`timescale 1ns/1ps

module aud_recorder (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_lrc,
    input  logic           i_start,
    input  logic           i_pause,
    input  logic           i_stop,
    input  logic           i_data,
    sample_if.client       mem,
    output mem_pkg::addr_t o_rec_len,
    output logic           o_recording
);

    audio_pkg::rec_state_t state_r, state_w;
    mem_pkg::addr_t        address_r, address_w;
    mem_pkg::addr_t        len_r, len_w;
    audio_pkg::sample_t    data_r, data_w;
    audio_pkg::bit_cnt_t   counter_r, counter_w;
    logic                  pause_r, pause_w;
    logic                  stop_r, stop_w;
    logic                  req_r, req_w;
    logic                  lrc_r;
    logic                  frame_start;

    assign frame_start = lrc_r && !i_lrc; // A frame opens when i_lrc drops.

    always_comb begin
        state_w   = state_r;
        address_w = address_r;
        len_w     = len_r;
        data_w    = data_r;
        counter_w = counter_r;
        pause_w   = pause_r;
        stop_w    = stop_r;
        req_w     = req_r;
        case (state_r)
            audio_pkg::R_IDLE: begin
                if (i_start) begin
                    address_w = '0;
                    len_w     = '0;
                    pause_w   = 1'b0;
                    stop_w    = 1'b0;
                    state_w   = audio_pkg::R_WAIT;
                end
            end
            audio_pkg::R_WAIT: begin
                if (i_stop) begin
                    state_w = audio_pkg::R_FINISH;
                end
                else if (i_pause) begin
                    pause_w = 1'b1;
                    state_w = audio_pkg::R_PAUSE;
                end
                else if (frame_start) begin
                    counter_w = '0;
                    state_w   = audio_pkg::R_REC;
                end
            end
            audio_pkg::R_REC: begin
                if (i_stop) begin
                    state_w = audio_pkg::R_FINISH; // The partial sample is dropped.
                end
                else begin
                    if (i_pause) begin
                        pause_w = !pause_r; // Takes effect once this sample is stored.
                    end
                    data_w    = {data_r[audio_pkg::SAMPLE_BITS-2:0], i_data};
                    counter_w = counter_r + 1'b1;
                    if (counter_r == audio_pkg::LAST_BIT) begin
                        req_w   = 1'b1;
                        state_w = audio_pkg::R_WRITE;
                    end
                end
            end
            audio_pkg::R_WRITE: begin
                if (i_stop) begin
                    stop_w = 1'b1;
                end
                if (i_pause) begin
                    pause_w = !pause_r;
                end
                // Hold req until ack, then wait for ack to clear.
                if (req_r && mem.ack) begin
                    req_w = 1'b0;
                end
                else if (!req_r && !mem.ack) begin
                    address_w = address_r + 1'b1;
                    if (stop_w || address_r == mem_pkg::LAST_ADDR) begin
                        state_w = audio_pkg::R_FINISH;
                    end
                    else if (pause_w) begin
                        state_w = audio_pkg::R_PAUSE;
                    end
                    else begin
                        state_w = audio_pkg::R_WAIT;
                    end
                end
            end
            audio_pkg::R_PAUSE: begin
                if (i_stop) begin
                    state_w = audio_pkg::R_FINISH;
                end
                else if (i_pause) begin
                    pause_w = 1'b0;
                    state_w = audio_pkg::R_WAIT;
                end
            end
            audio_pkg::R_FINISH: begin
                len_w   = address_r;
                state_w = audio_pkg::R_IDLE;
            end
            default: begin
                state_w = audio_pkg::R_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= audio_pkg::R_IDLE;
            address_r <= '0;
            len_r     <= '0;
            counter_r <= '0;
            pause_r   <= 1'b0;
            stop_r    <= 1'b0;
            req_r     <= 1'b0;
            lrc_r     <= 1'b0;
        end
        else begin
            state_r   <= state_w;
            address_r <= address_w;
            len_r     <= len_w;
            counter_r <= counter_w;
            pause_r   <= pause_w;
            stop_r    <= stop_w;
            req_r     <= req_w;
            lrc_r     <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        data_r <= data_w;
    end

    assign mem.req   = req_r;
    assign mem.we    = 1'b1;
    assign mem.addr  = address_r;
    assign mem.wdata = data_r;

    assign o_rec_len   = len_r;
    assign o_recording = (state_r != audio_pkg::R_IDLE) && (state_r != audio_pkg::R_FINISH);

endmodule

// ==== hw/aud_player.sv ====
`timescale 1ns/1ps

module aud_player (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_lrc,
    input  logic           i_start,
    input  logic           i_stop,
    input  mem_pkg::addr_t i_len,
    sample_if.client       mem,
    output logic           o_dac_data,
    output logic           o_playing
);

    audio_pkg::play_state_t state_r, state_w;
    mem_pkg::addr_t         address_r, address_w;
    audio_pkg::sample_t     shift_r, shift_w;
    audio_pkg::bit_cnt_t    counter_r, counter_w;
    logic                   stop_r, stop_w;
    logic                   req_r, req_w;
    logic                   dac_r, dac_w;
    logic                   lrc_r;
    logic                   frame_start;

    assign frame_start = lrc_r && !i_lrc;

    always_comb begin
        state_w   = state_r;
        address_w = address_r;
        shift_w   = shift_r;
        counter_w = counter_r;
        stop_w    = stop_r;
        req_w     = req_r;
        dac_w     = dac_r;
        case (state_r)
            audio_pkg::P_IDLE: begin
                if (i_start) begin
                    address_w = '0;
                    counter_w = '0;
                    stop_w    = 1'b0;
                    if (i_len == '0) begin
                        state_w = audio_pkg::P_DONE;
                    end
                    else begin
                        req_w   = 1'b1;
                        state_w = audio_pkg::P_FETCH;
                    end
                end
            end
            audio_pkg::P_FETCH: begin
                // A stop here waits for the open handshake to close.
                if (i_stop) begin
                    stop_w = 1'b1;
                end
                if (req_r && mem.ack) begin
                    shift_w = mem.rdata;
                    req_w   = 1'b0;
                end
                else if (!req_r && !mem.ack) begin
                    state_w = stop_w ? audio_pkg::P_DONE : audio_pkg::P_WAIT_LOW;
                end
            end
            audio_pkg::P_WAIT_LOW: begin
                if (i_stop) begin
                    state_w = audio_pkg::P_DONE;
                end
                else if (frame_start) begin
                    dac_w     = shift_r[audio_pkg::SAMPLE_BITS-1]; // MSB leads the frame.
                    shift_w   = {shift_r[audio_pkg::SAMPLE_BITS-2:0], 1'b0};
                    counter_w = '0;
                    state_w   = audio_pkg::P_SHIFT;
                end
            end
            audio_pkg::P_SHIFT: begin
                if (i_stop) begin
                    dac_w   = 1'b0;
                    state_w = audio_pkg::P_DONE;
                end
                else if (counter_r != audio_pkg::LAST_BIT) begin
                    dac_w     = shift_r[audio_pkg::SAMPLE_BITS-1];
                    shift_w   = {shift_r[audio_pkg::SAMPLE_BITS-2:0], 1'b0};
                    counter_w = counter_r + 1'b1;
                end
                else begin
                    dac_w = 1'b0;
                    if (i_lrc) begin
                        // Next fetch runs in the high half.
                        address_w = address_r + 1'b1;
                        if (address_w == i_len) begin
                            state_w = audio_pkg::P_DONE;
                        end
                        else begin
                            req_w   = 1'b1;
                            state_w = audio_pkg::P_FETCH;
                        end
                    end
                end
            end
            audio_pkg::P_DONE: begin
                dac_w   = 1'b0;
                state_w = audio_pkg::P_IDLE;
            end
            default: begin
                state_w = audio_pkg::P_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r   <= audio_pkg::P_IDLE;
            address_r <= '0;
            counter_r <= '0;
            stop_r    <= 1'b0;
            req_r     <= 1'b0;
            dac_r     <= 1'b0;
            lrc_r     <= 1'b0;
        end
        else begin
            state_r   <= state_w;
            address_r <= address_w;
            counter_r <= counter_w;
            stop_r    <= stop_w;
            req_r     <= req_w;
            dac_r     <= dac_w;
            lrc_r     <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

    assign mem.req   = req_r;
    assign mem.we    = 1'b0;
    assign mem.addr  = address_r;
    assign mem.wdata = '0;

    assign o_dac_data = dac_r;
    assign o_playing  = (state_r != audio_pkg::P_IDLE) && (state_r != audio_pkg::P_DONE);

endmodule

// ==== hw/sample_store.sv ====
`timescale 1ns/1ps

module sample_store (
    input  logic    i_clk,
    input  logic    i_rst_n,
    sample_if.store rec_port,
    sample_if.store play_port
);

    audio_pkg::sample_t            mem_q [mem_pkg::MEM_DEPTH];
    audio_pkg::sample_t            rdata_r;
    logic                          rec_ack_r;
    logic                          play_ack_r;
    logic                          busy;
    logic                          grant_rec;
    logic                          grant_play;
    logic                          sel_we;
    mem_pkg::addr_t                sel_addr;
    audio_pkg::sample_t            sel_wdata;
    logic [mem_pkg::IDX_BITS-1:0]  sel_idx;

    // Only one handshake may be open at a time.
    assign busy = rec_ack_r || play_ack_r;

    // The recorder wins a tie; the player keeps its req up and waits.
    assign grant_rec  = !busy && rec_port.req;
    assign grant_play = !busy && play_port.req && !rec_port.req;

    always_comb begin
        if (grant_rec) begin
            sel_we    = rec_port.we;
            sel_addr  = rec_port.addr;
            sel_wdata = rec_port.wdata;
        end
        else begin
            sel_we    = play_port.we;
            sel_addr  = play_port.addr;
            sel_wdata = play_port.wdata;
        end
    end

    assign sel_idx = sel_addr[mem_pkg::IDX_BITS-1:0]; // Upper address bits wrap.

    always_ff @(posedge i_clk) begin
        if (grant_rec || grant_play) begin
            if (sel_we) begin
                mem_q[sel_idx] <= sel_wdata;
            end
            else begin
                rdata_r <= mem_q[sel_idx];
            end
        end
    end

    // Ack rises the cycle after a granted req and stays up until req is seen low.
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            rec_ack_r  <= 1'b0;
            play_ack_r <= 1'b0;
        end
        else begin
            rec_ack_r  <= grant_rec || (rec_ack_r && rec_port.req);
            play_ack_r <= grant_play || (play_ack_r && play_port.req);
        end
    end

    assign rec_port.ack    = rec_ack_r;
    assign rec_port.rdata  = rdata_r;
    assign play_port.ack   = play_ack_r;
    assign play_port.rdata = rdata_r;

endmodule

// ==== hw/aud_top.sv ====
`timescale 1ns/1ps

module aud_top (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_lrc,
    input  logic           i_adc_data,
    input  logic           i_rec_start,
    input  logic           i_rec_pause,
    input  logic           i_rec_stop,
    input  logic           i_play_start,
    input  logic           i_play_stop,
    output logic           o_dac_data,
    output logic           o_recording,
    output logic           o_playing,
    output mem_pkg::addr_t o_rec_len
);

    sample_if rec_bus ();
    sample_if play_bus ();

    aud_recorder u_recorder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_start     (i_rec_start),
        .i_pause     (i_rec_pause),
        .i_stop      (i_rec_stop),
        .i_data      (i_adc_data),
        .mem         (rec_bus.client),
        .o_rec_len   (o_rec_len),
        .o_recording (o_recording)
    );

    // Playback length follows the last finished recording.
    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (i_play_start),
        .i_stop     (i_play_stop),
        .i_len      (o_rec_len),
        .mem        (play_bus.client),
        .o_dac_data (o_dac_data),
        .o_playing  (o_playing)
    );

    sample_store u_store (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .rec_port  (rec_bus.store),
        .play_port (play_bus.store)
    );

endmodule

// ==== tb/aud_properties.sv ====
`timescale 1ns/1ps

module aud_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_rec_req,
    input logic i_rec_ack,
    input logic i_play_req,
    input logic i_play_ack
);

    // A client keeps req up until the store answers.
    rec_req_held: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_rec_req && !i_rec_ack |=> i_rec_req)
        else $error("recorder dropped req before ack");
    play_req_held: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_play_req && !i_play_ack |=> i_play_req)
        else $error("player dropped req before ack");

    rec_ack_rise: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $rose(i_rec_ack) |-> i_rec_req)
        else $error("recorder ack rose without req");
    play_ack_rise: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $rose(i_play_ack) |-> i_play_req)
        else $error("player ack rose without req");

    // Ack may only fall once req was seen low.
    rec_ack_fall: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $fell(i_rec_ack) |-> !$past(i_rec_req))
        else $error("recorder ack fell while req was high");
    play_ack_fall: assert property (@(posedge i_clk) disable iff (i_rst_n)
        $fell(i_play_ack) |-> !$past(i_play_req))
        else $error("player ack fell while req was high");

    one_port_acked: assert property (@(posedge i_clk) disable iff (i_rst_n)
        !(i_rec_ack && i_play_ack))
        else $error("both store ports acked together");

endmodule

bind sample_store aud_properties u_props (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rec_req  (rec_port.req),
    .i_rec_ack  (rec_port.ack),
    .i_play_req (play_port.req),
    .i_play_ack (play_port.ack)
);

// ==== tb/aud_tb.sv ====
`timescale 1ns/1ps

module aud_tb;

    typedef audio_pkg::sample_t sample_q_t[$];
    typedef bit flag_q_t[$];

    localparam logic [4:0] KEY_REC_START  = 5'b10000;
    localparam logic [4:0] KEY_REC_PAUSE  = 5'b01000;
    localparam logic [4:0] KEY_REC_STOP   = 5'b00100;
    localparam logic [4:0] KEY_PLAY_START = 5'b00010;
    localparam logic [4:0] KEY_PLAY_STOP  = 5'b00001;
    localparam int GAP_CYCLES = 8;

    // Frames sent while recording and while playing, summed over all tests.
    localparam int REC_FRAMES  = 12 + 10 + 8 + (mem_pkg::MEM_DEPTH + 4) + 5;
    localparam int PLAY_FRAMES = 12 + 7 + 5 + 5;
    localparam int MAX_CYCLES  = 2 * (REC_FRAMES + PLAY_FRAMES) * audio_pkg::FRAME_CYCLES;

    logic i_clk, i_rst_n, i_lrc, i_adc_data;
    logic i_rec_start, i_rec_pause, i_rec_stop, i_play_start, i_play_stop;
    logic o_dac_data, o_recording, o_playing;
    mem_pkg::addr_t o_rec_len;

    integer    seed = 32'hfa8ebe93;
    sample_q_t sent_q;
    flag_q_t   skip_q;   // Set for frames sent while the recorder was paused.
    sample_q_t exp_q;
    int        errors = 0;
    int        mark = 0;
    int        passed = 0;
    int        failed = 0;
    int        cycles = 0;

    aud_top u_aud_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // Playback samples the DUT should produce, given what was sent and skipped.
    function automatic sample_q_t expected_playback(sample_q_t sent, flag_q_t skipped,
                                                    int max_frames);
        sample_q_t kept;
        foreach (sent[i]) begin
            if (!skipped[i] && kept.size() < mem_pkg::MEM_DEPTH) begin
                kept.push_back(sent[i]);
            end
        end
        while (kept.size() > max_frames) begin
            void'(kept.pop_back());
        end
        return kept;
    endfunction

    task automatic check_sample(input string name, input audio_pkg::sample_t got,
                                input audio_pkg::sample_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input mem_pkg::addr_t got,
                             input mem_pkg::addr_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Low half carries the sample MSB first on the 16 cycles after i_lrc drops.
    task automatic send_frame(input audio_pkg::sample_t s);
        for (int k = 0; k < audio_pkg::FRAME_CYCLES; k++) begin
            @(negedge i_clk);
            i_lrc = (k >= audio_pkg::HALF_FRAME_CYCLES);
            if (k >= 1 && k <= audio_pkg::SAMPLE_BITS) begin
                i_adc_data = s[audio_pkg::SAMPLE_BITS-k];
            end
            else begin
                i_adc_data = 1'b0;
            end
        end
    endtask

    task automatic record_frame(input bit skipped);
        audio_pkg::sample_t s;
        s = audio_pkg::sample_t'($random(seed));
        sent_q.push_back(s);
        skip_q.push_back(skipped);
        send_frame(s);
    endtask

    task automatic press(input logic [4:0] keys);
        @(negedge i_clk);
        {i_rec_start, i_rec_pause, i_rec_stop, i_play_start, i_play_stop} = keys;
        @(negedge i_clk);
        {i_rec_start, i_rec_pause, i_rec_stop, i_play_start, i_play_stop} = '0;
        repeat (GAP_CYCLES) @(negedge i_clk);
    endtask

    task automatic apply_reset();
        i_rst_n = 1'b1;
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b0;
    endtask

    task automatic check_recording();
        sample_q_t kept;
        kept = expected_playback(sent_q, skip_q, mem_pkg::MEM_DEPTH);
        check_len("o_rec_len", o_rec_len, mem_pkg::addr_t'(kept.size()));
        check_bit("o_recording", o_recording, 1'b0);
    endtask

    task automatic play_all();
        exp_q = expected_playback(sent_q, skip_q, mem_pkg::MEM_DEPTH);
        press(KEY_PLAY_START);
        while (o_playing) begin
            send_frame('0);
        end
        if (exp_q.size() != 0) begin
            $display("playback ended with %0d samples never played", exp_q.size());
            errors++;
        end
    endtask

    task automatic begin_test();
        sent_q.delete();
        skip_q.delete();
        mark = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            passed++;
            $display("%s: ok", name);
        end
        else begin
            failed++;
            $display("%s: FAILED with %0d errors", name, errors - mark);
        end
    endtask

    // Rebuilds each played sample from the DAC line and compares it in order.
    initial begin : dac_monitor
        audio_pkg::sample_t got;
        got = '0;
        forever begin
            @(negedge i_lrc);
            if (o_playing) begin
                repeat (audio_pkg::SAMPLE_BITS) begin
                    @(negedge i_clk);
                    got = {got[audio_pkg::SAMPLE_BITS-2:0], o_dac_data};
                end
                if (exp_q.size() == 0) begin
                    $display("player sent sample %h when none was expected", got);
                    errors++;
                end
                else begin
                    check_sample("o_dac_data", got, exp_q.pop_front());
                end
            end
        end
    end

    always @(negedge i_clk) begin
        if (!i_rst_n && !o_playing && o_dac_data !== 1'b0) begin
            $display("o_dac_data is not low while the player is idle");
            errors++;
        end
    end

    initial begin
        i_rst_n      = 1'b1;
        i_lrc        = 1'b1;
        i_adc_data   = 1'b0;
        i_rec_start  = 1'b0;
        i_rec_pause  = 1'b0;
        i_rec_stop   = 1'b0;
        i_play_start = 1'b0;
        i_play_stop  = 1'b0;
        apply_reset();

        begin_test();
        press(KEY_REC_START);
        repeat (12) record_frame(1'b0);
        press(KEY_REC_STOP);
        check_recording();
        play_all();
        end_test("record and play back");

        begin_test();
        press(KEY_REC_START);
        repeat (3) record_frame(1'b0);
        press(KEY_REC_PAUSE);
        repeat (3) record_frame(1'b1);
        press(KEY_REC_PAUSE);
        repeat (4) record_frame(1'b0);
        press(KEY_REC_STOP);
        check_recording();
        play_all();
        end_test("pause and resume");

        begin_test();
        press(KEY_REC_START);
        repeat (8) record_frame(1'b0);
        press(KEY_REC_STOP);
        check_recording();
        exp_q = expected_playback(sent_q, skip_q, 3);
        press(KEY_PLAY_START);
        repeat (3) send_frame('0);
        press(KEY_PLAY_STOP);
        check_bit("o_playing", o_playing, 1'b0);
        repeat (2) send_frame('0); // The idle monitor watches the DAC line here.
        if (exp_q.size() != 0) begin
            $display("stopped playback left %0d samples unplayed", exp_q.size());
            errors++;
        end
        end_test("stop during playback");

        begin_test();
        press(KEY_REC_START);
        check_bit("o_recording", o_recording, 1'b1);
        repeat (mem_pkg::MEM_DEPTH + 4) record_frame(1'b0);
        check_recording();
        end_test("full store");

        begin_test();
        press(KEY_REC_START);
        repeat (5) record_frame(1'b0);
        press(KEY_REC_STOP);
        check_recording();
        play_all();
        end_test("restart recording");

        begin_test();
        press(KEY_REC_START);
        press(KEY_PLAY_START); // Both modes are busy when reset hits.
        apply_reset();
        @(negedge i_clk);
        check_bit("o_recording", o_recording, 1'b0);
        check_bit("o_playing", o_playing, 1'b0);
        check_bit("o_dac_data", o_dac_data, 1'b0);
        check_len("o_rec_len", o_rec_len, '0);
        end_test("reset state");

        $display("%0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end
        else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/audio_pkg.sv
hw/mem_pkg.sv
hw/sample_if.sv
hw/aud_recorder.sv
hw/aud_player.sv
hw/sample_store.sv
hw/aud_top.sv
tb/aud_properties.sv
tb/aud_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module aud_tb -o aud_sim

status=0
./obj_dir/aud_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status, see sim.log"
    exit 1
fi
echo "simulation passed"
